//--- hdl/fe_cfg_pkg.sv
package fe_cfg_pkg;

  // Datapath widths
  localparam int xlen        = 32;
  localparam int fetch_width = 4;   // Lanes per fetched block
  localparam int issue_width = 2;   // Max pops and issues per cycle
  localparam int block_bytes = 16;  // Block address has low bits clear

  // ----------------------------------------------------------------------
  // Derived sizes
  // ----------------------------------------------------------------------
  localparam int blk_width    = xlen * fetch_width;
  localparam int word_bits    = $clog2(xlen / 8);      // Byte offset within a word
  localparam int blk_off_bits = $clog2(block_bytes);   // Byte offset within a block

endpackage

//--- hdl/fe_instr_pkg.sv
package fe_instr_pkg;

  typedef struct packed {
    logic [fe_cfg_pkg::xlen-1:0] instr;
    logic [fe_cfg_pkg::xlen-1:0] pc;
  } ib_entry_t;

  typedef enum logic [2:0] {
    cls_alu, cls_load, cls_store, cls_branch,
    cls_jump, cls_system, cls_illegal
  } instr_class_e;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_system = 7'b1110011;

endpackage

//--- hdl/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
  import fe_cfg_pkg::*;
#(
  parameter int IB_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      redirect,
  input  logic [xlen-1:0]           redirect_pc,
  output logic                      mem_req,
  output logic [xlen-1:0]           mem_addr,
  input  logic                      mem_ack,
  input  logic [blk_width-1:0]      mem_data,
  input  logic [$clog2(IB_DEPTH):0] count,
  output logic [blk_width-1:0]      blk_data,
  output logic [xlen-1:0]           fetch_pc,
  input  logic [2:0]                lane_push,
  output logic [2:0]                push_num
);

  localparam int cw = $clog2(IB_DEPTH) + 1;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_ack,
    st_wait_release
  } state_e;

  state_e          state_q;
  logic [xlen-1:0] pc_q;
  logic            stale_q;     // Outstanding request was overtaken by a redirect
  logic            start;
  logic            take;
  logic [cw-1:0]   free_slots;

  assign free_slots = cw'(IB_DEPTH) - count;

  // New request needs a whole block of room and a released ack
  assign start = (state_q == st_idle) && !mem_ack && !redirect &&
                 (free_slots >= fetch_width);
  assign take  = (state_q == st_wait_ack) && mem_ack;

  assign blk_data = mem_data;
  assign fetch_pc = pc_q;
  assign push_num = (take && !stale_q && !redirect) ? lane_push : 3'd0;

  // ----------------------------------------------------------------------
  // Four-phase request FSM and PC
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= st_idle;
      mem_req  <= 1'b0;
      mem_addr <= '0;
      pc_q     <= '0;
      stale_q  <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            mem_req  <= 1'b1;
            mem_addr <= {pc_q[xlen-1:blk_off_bits], {blk_off_bits{1'b0}}};
            state_q  <= st_wait_ack;
          end
        end
        st_wait_ack: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            stale_q <= 1'b0;
            state_q <= st_wait_release;
          end
        end
        st_wait_release: begin
          if (!mem_ack) state_q <= st_idle;  // Memory has dropped its ack
        end
        default: state_q <= st_idle;
      endcase

      if (redirect) begin
        pc_q <= redirect_pc;
      end else if (take && !stale_q) begin
        pc_q <= mem_addr + xlen'(block_bytes);  // Next sequential block
      end

      if (redirect && (state_q == st_wait_ack) && !mem_ack) stale_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Handshake rules
  // ----------------------------------------------------------------------
  a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req) |-> !mem_ack);

endmodule

//--- hdl/fetch_aligner.sv
`timescale 1ns/1ps

module fetch_aligner
  import fe_cfg_pkg::*;
  import fe_instr_pkg::*;
(
  input  logic [xlen-1:0]             fetch_pc,
  input  logic [blk_width-1:0]        blk_data,
  output ib_entry_t [fetch_width-1:0] lane,
  output logic [2:0]                  lane_push
);

  localparam int ow = $clog2(fetch_width);

  logic [ow-1:0]        word_off;
  logic [blk_width-1:0] shifted;
  logic [xlen-1:0]      base_pc;

  // Word index of the fetch PC inside its block
  assign word_off = fetch_pc[blk_off_bits-1:word_bits];
  assign base_pc  = {fetch_pc[xlen-1:word_bits], {word_bits{1'b0}}};

  // Drop the lanes that come before the fetch PC
  assign shifted   = blk_data >> (word_off * xlen);
  assign lane_push = 3'(fetch_width) - 3'(word_off);

  always_comb begin
    for (int i = 0; i < fetch_width; i++) begin
      lane[i].instr = shifted[i*xlen +: xlen];
      lane[i].pc    = base_pc + xlen'(i * (xlen / 8));  // Upper lanes past push count unused
    end
  end

endmodule

//--- hdl/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer
  import fe_cfg_pkg::*;
  import fe_instr_pkg::*;
#(
  parameter int IB_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        flush,
  input  ib_entry_t [fetch_width-1:0] push_entry,
  input  logic [2:0]                  push_num,
  input  logic [1:0]                  pop_num,
  output ib_entry_t                   head0,
  output ib_entry_t                   head1,
  output logic [$clog2(IB_DEPTH):0]   count
);

  localparam int aw = $clog2(IB_DEPTH);
  localparam int cw = aw + 1;

  ib_entry_t     slots [IB_DEPTH];
  logic [aw-1:0] head_q;
  logic [aw-1:0] tail_q;
  logic [cw-1:0] count_q;

  // ----------------------------------------------------------------------
  // Storage written at the tail and the slots after it
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < fetch_width; i++) begin
      if (i < push_num) slots[tail_q + aw'(i)] <= push_entry[i];
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      tail_q  <= tail_q + aw'(push_num);
      head_q  <= head_q + aw'(pop_num);
      count_q <= count_q + cw'(push_num) - cw'(pop_num);  // Push and pop on the same edge
    end
  end

  assign count = count_q;
  assign head0 = slots[head_q];
  assign head1 = slots[head_q + 1'b1];  // Wraps with the pointer

  // Fetch side must never overfill and decode side never over-pop
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (count_q + cw'(push_num)) <= IB_DEPTH);

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop_num <= count_q);

endmodule

//--- hdl/dual_decoder.sv
`timescale 1ns/1ps

module dual_decoder
  import fe_cfg_pkg::*;
  import fe_instr_pkg::*;
#(
  parameter int IB_DEPTH = 16
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush,
  input  ib_entry_t                         head0,
  input  ib_entry_t                         head1,
  input  logic [$clog2(IB_DEPTH):0]         count,
  output logic [1:0]                        pop_num,
  output logic [issue_width-1:0]            issue_valid,
  output logic [issue_width-1:0][xlen-1:0]  issue_instr,
  output logic [issue_width-1:0][xlen-1:0]  issue_pc,
  output instr_class_e [issue_width-1:0]    issue_class,
  input  logic                              issue_ready
);

  logic       load;
  logic [1:0] take;

  function automatic instr_class_e classify(input logic [xlen-1:0] instr);
    instr_class_e cls;
    case (instr[6:0])
      opc_op, opc_op_imm, opc_lui, opc_auipc: cls = cls_alu;
      opc_load:                               cls = cls_load;
      opc_store:                              cls = cls_store;
      opc_branch:                             cls = cls_branch;
      opc_jal, opc_jalr:                      cls = cls_jump;
      opc_system:                             cls = cls_system;
      default:                                cls = cls_illegal;
    endcase
    return cls;
  endfunction

  assign load = !issue_valid[0] || issue_ready;  // Stage empty or being drained
  assign take = (count >= issue_width) ? 2'(issue_width) : count[1:0];
  assign pop_num = (load && !flush) ? take : 2'd0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid <= '0;
    end else if (flush) begin
      issue_valid <= '0;
    end else if (load) begin
      issue_valid <= {take == 2'd2, take != 2'd0};  // Slot 1 only behind slot 0
    end
  end

  // Issue payload
  always_ff @(posedge clk) begin
    if (load) begin
      issue_instr[0] <= head0.instr;
      issue_pc[0]    <= head0.pc;
      issue_class[0] <= classify(head0.instr);
      issue_instr[1] <= head1.instr;
      issue_pc[1]    <= head1.pc;
      issue_class[1] <= classify(head1.instr);
    end
  end

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
  import fe_cfg_pkg::*;
  import fe_instr_pkg::*;
#(
  parameter int IB_DEPTH = 16
) (
  input  logic                             clk,
  input  logic                             rst_n,
  output logic                             mem_req,
  output logic [xlen-1:0]                  mem_addr,
  input  logic                             mem_ack,
  input  logic [blk_width-1:0]             mem_data,
  input  logic                             redirect,
  input  logic [xlen-1:0]                  redirect_pc,
  output logic [issue_width-1:0]           issue_valid,
  output logic [issue_width-1:0][xlen-1:0] issue_instr,
  output logic [issue_width-1:0][xlen-1:0] issue_pc,
  output instr_class_e [issue_width-1:0]   issue_class,
  input  logic                             issue_ready
);

  logic [blk_width-1:0]        blk_data;
  logic [xlen-1:0]             fetch_pc;
  ib_entry_t [fetch_width-1:0] lane;
  logic [2:0]                  lane_push;
  logic [2:0]                  push_num;
  logic [$clog2(IB_DEPTH):0]   count;
  ib_entry_t                   head0;
  ib_entry_t                   head1;
  logic [1:0]                  pop_num;

  fetch_ctrl #(.IB_DEPTH(IB_DEPTH)) u_ctrl (
    .clk, .rst_n, .redirect, .redirect_pc, .mem_req, .mem_addr, .mem_ack, .mem_data,
    .count, .blk_data, .fetch_pc, .lane_push, .push_num
  );

  fetch_aligner u_align (.fetch_pc, .blk_data, .lane, .lane_push);

  // Redirect flushes the buffer and the issue stage
  instr_buffer #(.IB_DEPTH(IB_DEPTH)) u_ib (
    .clk, .rst_n, .flush(redirect), .push_entry(lane), .push_num, .pop_num,
    .head0, .head1, .count
  );

  dual_decoder #(.IB_DEPTH(IB_DEPTH)) u_dec (
    .clk, .rst_n, .flush(redirect), .head0, .head1, .count, .pop_num,
    .issue_valid, .issue_instr, .issue_pc, .issue_class, .issue_ready
  );

endmodule

//--- verif/imem_model.sv
`timescale 1ns/1ps

module imem_model
  import fe_cfg_pkg::*;
  import fe_instr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 mem_req,
  input  logic [xlen-1:0]      mem_addr,
  output logic                 mem_ack,
  output logic [blk_width-1:0] mem_data
);

  // Seven legal opcodes and one illegal one picked by word bits 2..0
  localparam logic [6:0] opc_tab [8] = '{
    opc_op, opc_lui, opc_load, opc_store, opc_branch, opc_jal, opc_system, 7'b1111111
  };

  integer               seed = 32'haeef;
  integer               wait_cnt;
  logic                 busy;  // Request seen and ack still pending
  logic [blk_width-1:0] blk;

  function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] addr);
    return {addr[26:2], opc_tab[addr[4:2]]};
  endfunction

  always_comb begin
    for (int i = 0; i < fetch_width; i++) begin
      blk[i*xlen +: xlen] = word_at(mem_addr + xlen'(i * 4));  // Lane 0 lowest
    end
  end

  initial begin
    mem_ack  <= 1'b0;
    mem_data <= '0;
    busy     <= 1'b0;
    wait_cnt <= 0;
  end

  // ----------------------------------------------------------------------
  // Four-phase responder that changes its outputs on the falling edge
  // ----------------------------------------------------------------------
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_ack <= 1'b0;
      busy    <= 1'b0;
    end else if (mem_ack) begin
      if (!mem_req) mem_ack <= 1'b0;  // Release once the request is gone
    end else if (busy) begin
      if (wait_cnt == 0) begin
        mem_ack  <= 1'b1;
        mem_data <= blk;
        busy     <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end else if (mem_req) begin
      busy     <= 1'b1;
      wait_cnt <= $unsigned($random(seed)) % 6;  // 0 to 5 extra cycles
    end
  end

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
  import fe_cfg_pkg::*;
  import fe_instr_pkg::*;
();

  localparam int ib_depth    = 16;
  localparam int run_cycles  = 2000;
  localparam int calm_cycles = 400;  // Final stretch with issue_ready held high
  localparam int stall_limit = 40;

  // Memory opcode table and the class each entry must decode to
  localparam logic [6:0] opc_tab [8] = '{
    opc_op, opc_lui, opc_load, opc_store, opc_branch, opc_jal, opc_system, 7'b1111111
  };
  localparam instr_class_e cls_tab [8] = '{
    cls_alu, cls_alu, cls_load, cls_store, cls_branch, cls_jump, cls_system, cls_illegal
  };

  logic                             clk;
  logic                             rst_n;
  logic                             redirect;
  logic [xlen-1:0]                  redirect_pc;
  logic                             issue_ready;
  logic                             mem_req;
  logic [xlen-1:0]                  mem_addr;
  logic                             mem_ack;
  logic [blk_width-1:0]             mem_data;
  logic [issue_width-1:0]           issue_valid;
  logic [issue_width-1:0][xlen-1:0] issue_instr;
  logic [issue_width-1:0][xlen-1:0] issue_pc;
  instr_class_e [issue_width-1:0]   issue_class;

  integer          seed = 32'haeef;
  logic [xlen-1:0] exp_pc;       // Next PC in program order
  int              idle_cycles;  // Ready cycles without a transfer

  fetch_top #(.IB_DEPTH(ib_depth)) dut (.*);
  imem_model u_mem (.*);

  function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] addr);
    return {addr[26:2], opc_tab[addr[4:2]]};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [xlen-1:0] exp,
                                 input logic [xlen-1:0] act);
    stop_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic wait_first_issue();
    int n;
    n = 0;
    while (!issue_valid[0]) begin
      @(negedge clk);
      n++;
      if (n > stall_limit) stop_run("timeout waiting for the first issue after reset");
    end
  endtask

  task automatic drive_cycle(input bit random_mode);
    integer r;
    r = $random(seed);
    redirect = 1'b0;
    if (!random_mode) begin
      issue_ready = 1'b1;
    end else begin
      issue_ready = (r[1:0] != 2'b00);
      // Extra chance of a redirect while a block is in flight
      if (r[9:4] == 6'd0 || (mem_req && r[13:10] == 4'd0)) begin
        redirect    = 1'b1;
        redirect_pc = $random(seed) & 32'h000f_fffc;  // Any word inside a block
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    issue_ready = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    if (mem_req !== 1'b0) stop_run("mem_req is not low after reset");
    if (issue_valid !== '0) stop_run("issue_valid is not low after reset");
    issue_ready = 1'b1;
    wait_first_issue();
    for (int n = 0; n < run_cycles; n++) begin
      @(negedge clk);
      drive_cycle(n < run_cycles - calm_cycles);
    end
    $display("Verification passed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Reference PC and progress watchdog
  // ----------------------------------------------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc      <= '0;
      idle_cycles <= 0;
    end else begin
      if (issue_ready && issue_valid[0]) exp_pc <= exp_pc + (issue_valid[1] ? 8 : 4);
      if (redirect) exp_pc <= redirect_pc;  // Flush restarts the stream here
      if (redirect || (issue_ready && issue_valid[0])) idle_cycles <= 0;
      else if (issue_ready) idle_cycles <= idle_cycles + 1;
      if (idle_cycles >= stall_limit) stop_run("front end stalled, no issue within 40 cycles");
    end
  end

  // ----------------------------------------------------------------------
  // Issue port checks
  // ----------------------------------------------------------------------
  a_pc0: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[0] |-> issue_pc[0] == exp_pc)
    else report_mismatch("issue_pc[0]", $sampled(exp_pc), $sampled(issue_pc[0]));
  a_pc1: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[1] |-> issue_pc[1] == issue_pc[0] + 4)
    else report_mismatch("issue_pc[1]", $sampled(issue_pc[0]) + 4, $sampled(issue_pc[1]));
  a_slot_order: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[1] |-> issue_valid[0]) else stop_run("slot 1 issued without slot 0");
  a_instr0: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[0] |-> issue_instr[0] == word_at(issue_pc[0]))
    else report_mismatch("issue_instr[0]", word_at($sampled(issue_pc[0])),
                         $sampled(issue_instr[0]));
  a_instr1: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[1] |-> issue_instr[1] == word_at(issue_pc[1]))
    else report_mismatch("issue_instr[1]", word_at($sampled(issue_pc[1])),
                         $sampled(issue_instr[1]));
  a_class0: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[0] |-> issue_class[0] == cls_tab[issue_pc[0][4:2]])
    else report_mismatch("issue_class[0]", xlen'(cls_tab[$sampled(issue_pc[0][4:2])]),
                         xlen'($sampled(issue_class[0])));
  a_class1: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid[1] |-> issue_class[1] == cls_tab[issue_pc[1][4:2]])
    else report_mismatch("issue_class[1]", xlen'(cls_tab[$sampled(issue_pc[1][4:2])]),
                         xlen'($sampled(issue_class[1])));
  a_hold0: assert property (@(posedge clk) disable iff (!rst_n)
    !issue_ready && issue_valid[0] && !redirect |=> $stable(issue_valid) &&
    $stable(issue_pc[0]) && $stable(issue_instr[0]) && $stable(issue_class[0]))
    else stop_run("issue slot 0 changed while issue_ready was low");
  a_hold1: assert property (@(posedge clk) disable iff (!rst_n)
    !issue_ready && issue_valid[1] && !redirect |=> $stable(issue_pc[1]) &&
    $stable(issue_instr[1]) && $stable(issue_class[1]))
    else stop_run("issue slot 1 changed while issue_ready was low");

  // Memory port handshake
  a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mem_req) |-> !$past(mem_ack)) else stop_run("mem_req rose while mem_ack was high");
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && $past(mem_req) |-> $stable(mem_addr))
    else stop_run("mem_addr changed while mem_req was high");

endmodule

//--- project.f
hdl/fe_cfg_pkg.sv
hdl/fe_instr_pkg.sv
hdl/fetch_ctrl.sv
hdl/fetch_aligner.sv
hdl/instr_buffer.sv
hdl/dual_decoder.sv
hdl/fetch_top.sv
verif/imem_model.sv
verif/fetch_tb.sv
